//--- source/tomasulo_defs.svh
`ifndef TOMASULO_DEFS_SVH
`define TOMASULO_DEFS_SVH

// architectural register file
`define TOMA_NUM_REGS 32

// producer tag width, tag 0 means the value is present
`define TOMA_TAG_W 3

// station depths
`define TOMA_RS1_ENTRIES 3
`define TOMA_RS2_ENTRIES 2

// first tag of each station, entry tag = base + index
`define TOMA_RS1_TAG_BASE 1
`define TOMA_RS2_TAG_BASE 4

`endif

//--- source/tomasulo_pkg.sv
`include "tomasulo_defs.svh"

package tomasulo_pkg;

  typedef logic [`TOMA_TAG_W-1:0] tag_t;
  typedef logic [$clog2(`TOMA_NUM_REGS)-1:0] reg_idx_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // one instruction word, R view or I view
  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } instr_word_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  typedef struct packed {
    logic [31:0] value;
    tag_t        tag;   // nonzero while pending
  } operand_t;

  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    reg_idx_t rd;
    operand_t a;
    operand_t b;
  } issue_req_t;

  typedef struct packed {
    logic        valid;
    tag_t        tag;
    logic [31:0] value;
  } cdb_t;

  typedef struct packed {
    logic     busy;
    alu_op_e  op;
    reg_idx_t rd;
    operand_t a;
    operand_t b;
  } rs_entry_t;

endpackage

//--- source/alu.sv
`timescale 1ns/1ps

module alu import tomasulo_pkg::*; (
  input alu_op_e      op,
  input wire [31:0]   a,
  input wire [31:0]   b,
  output logic [31:0] y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_SLL:  y = a << shamt;
      ALU_SRL:  y = a >> shamt;
      ALU_SRA:  y = $signed(a) >>> shamt;
      ALU_SLT:  y = {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU: y = {31'd0, a < b};
      default:  y = '0;
    endcase
  end

endmodule

//--- source/issue_unit.sv
`timescale 1ns/1ps

module issue_unit import tomasulo_pkg::*; (
  input wire         clk_100mhz,
  input wire         arst_n,
  input wire         instr_valid,
  input instr_word_u instr,
  output logic       instr_ready,
  input wire         rs1_full,
  input wire         rs2_full,
  input tag_t        rs1_free_tag,
  input tag_t        rs2_free_tag,
  output reg_idx_t   rd_addr_a,
  output reg_idx_t   rd_addr_b,
  input operand_t    opnd_a,
  input operand_t    opnd_b,
  output logic       alloc_we,
  output reg_idx_t   alloc_rd,
  output tag_t       alloc_tag,
  output issue_req_t rs1_issue,
  output issue_req_t rs2_issue
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] F7_ZERO    = 7'b0000000;
  localparam logic [6:0] F7_ALT     = 7'b0100000;

  logic       is_op;
  logic       is_imm;
  logic [6:0] f7;
  logic       f7_legal;
  logic       supported;
  logic       to_shift;
  logic       accept;
  alu_op_e    op;
  operand_t   opnd_b_sel;
  issue_req_t req;

  assign is_op  = instr.r_fields.opcode == OPC_OP;
  assign is_imm = instr.i_fields.opcode == OPC_OP_IMM;
  assign f7     = is_imm ? instr.i_fields.imm12[11:5] : instr.r_fields.funct7; // shamt form

  always_comb begin
    case (instr.r_fields.funct3)
      3'b000:  op = (is_op && f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
  end

  always_comb begin
    f7_legal = 1'b1;
    if (instr.r_fields.funct3 == 3'b001) begin
      f7_legal = f7 == F7_ZERO;
    end else if (instr.r_fields.funct3 == 3'b101) begin
      f7_legal = (f7 == F7_ZERO) || (f7 == F7_ALT);
    end else if (is_op) begin
      f7_legal = (f7 == F7_ZERO) || (instr.r_fields.funct3 == 3'b000 && f7 == F7_ALT);
    end
  end

  assign supported   = (is_op || is_imm) && f7_legal;
  assign to_shift    = op inside {ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
  assign instr_ready = !supported || !(to_shift ? rs2_full : rs1_full); // drops never stall
  assign accept      = instr_valid && instr_ready && supported;

  assign rd_addr_a = instr.r_fields.rs1;
  assign rd_addr_b = instr.r_fields.rs2;

  always_comb begin
    if (is_imm) begin
      opnd_b_sel = '{value: {{20{instr.i_fields.imm12[11]}}, instr.i_fields.imm12}, tag: '0};
    end else begin
      opnd_b_sel = opnd_b;
    end
  end

  always_comb begin
    req       = '{valid: accept, op: op, rd: instr.r_fields.rd, a: opnd_a, b: opnd_b_sel};
    rs1_issue = req;
    rs2_issue = req;
    rs1_issue.valid = accept && !to_shift;
    rs2_issue.valid = accept && to_shift;
  end

  assign alloc_we  = accept;
  assign alloc_rd  = instr.r_fields.rd;
  assign alloc_tag = to_shift ? rs2_free_tag : rs1_free_tag;

endmodule

//--- source/reservation_station.sv
`timescale 1ns/1ps

module reservation_station import tomasulo_pkg::*; #(
  parameter int ENTRIES  = 3,
  parameter int TAG_BASE = 1
) (
  input wire         clk_100mhz,
  input wire         arst_n,
  input issue_req_t  issue,
  output logic       full,
  output tag_t       free_tag,
  input cdb_t        cdb,
  output cdb_t       result,
  input wire         grant,
  output logic       busy_any
);

  localparam int IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  rs_entry_t          ent [ENTRIES];
  logic [ENTRIES-1:0] held;      // dispatched, tag not yet on the bus
  logic [ENTRIES-1:0] busy_vec;
  logic [ENTRIES-1:0] free_vec;
  logic [ENTRIES-1:0] ready_vec;
  logic [IDX_W-1:0]   free_idx;
  logic [IDX_W-1:0]   sel_idx;
  logic               sel_valid;
  logic               dispatch;
  logic [31:0]        alu_y;

  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      busy_vec[i]  = ent[i].busy;
      free_vec[i]  = !ent[i].busy && !held[i];
      ready_vec[i] = ent[i].busy && ent[i].a.tag == '0 && ent[i].b.tag == '0;
    end
  end

  // lowest index wins in both searches
  always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_valid = 1'b0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        free_idx = IDX_W'(i);
      end
      if (ready_vec[i]) begin
        sel_idx   = IDX_W'(i);
        sel_valid = 1'b1;
      end
    end
  end

  assign full     = ~|free_vec;
  assign free_tag = tag_t'(TAG_BASE + int'(free_idx));
  assign busy_any = |busy_vec || |held;
  assign dispatch = sel_valid && (!result.valid || grant); // stall on back-pressure

  alu u_alu (
    .op (ent[sel_idx].op),
    .a  (ent[sel_idx].a.value),
    .b  (ent[sel_idx].b.value),
    .y  (alu_y)
  );

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        ent[i].busy <= 1'b0;
      end
      held <= '0;
    end else begin
      for (int i = 0; i < ENTRIES; i++) begin
        if (issue.valid && free_idx == IDX_W'(i)) begin
          ent[i] <= '{busy: 1'b1, op: issue.op, rd: issue.rd, a: issue.a, b: issue.b};
        end else begin
          if (dispatch && sel_idx == IDX_W'(i)) begin
            ent[i].busy <= 1'b0;
          end
          if (ent[i].busy && cdb.valid && ent[i].a.tag != '0 && cdb.tag == ent[i].a.tag) begin
            ent[i].a <= '{value: cdb.value, tag: '0};
          end
          if (ent[i].busy && cdb.valid && ent[i].b.tag != '0 && cdb.tag == ent[i].b.tag) begin
            ent[i].b <= '{value: cdb.value, tag: '0};
          end
        end
        if (dispatch && sel_idx == IDX_W'(i)) begin
          held[i] <= 1'b1;
        end else if (cdb.valid && cdb.tag == tag_t'(TAG_BASE + i)) begin
          held[i] <= 1'b0;   // tag free for reuse
        end
      end
    end
  end

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      result.valid <= 1'b0;
    end else if (dispatch) begin
      result <= '{valid: 1'b1, tag: tag_t'(TAG_BASE + int'(sel_idx)), value: alu_y};
    end else if (grant) begin
      result.valid <= 1'b0;
    end
  end

endmodule

//--- source/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter import tomasulo_pkg::*; (
  input wire    clk_100mhz,
  input wire    arst_n,
  input cdb_t   req1,
  input cdb_t   req2,
  output logic  grant1,
  output logic  grant2,
  output cdb_t  cdb
);

  logic last1;   // station one won the last grant

  // on contention the other station goes first
  assign grant1 = req1.valid && (!req2.valid || !last1);
  assign grant2 = req2.valid && !grant1;

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      last1 <= 1'b0;
    end else if (grant1 || grant2) begin
      last1 <= grant1;
    end
  end

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= grant1 || grant2;
      if (grant1) begin
        cdb.tag   <= req1.tag;
        cdb.value <= req1.value;
      end else if (grant2) begin
        cdb.tag   <= req2.tag;
        cdb.value <= req2.value;
      end
    end
  end

endmodule

//--- source/reg_status_file.sv
`timescale 1ns/1ps
`include "tomasulo_defs.svh"

module reg_status_file import tomasulo_pkg::*; (
  input wire          clk_100mhz,
  input wire          arst_n,
  input reg_idx_t     rd_addr_a,
  input reg_idx_t     rd_addr_b,
  output operand_t    opnd_a,
  output operand_t    opnd_b,
  input wire          alloc_we,
  input reg_idx_t     alloc_rd,
  input tag_t         alloc_tag,
  input cdb_t         cdb,
  input reg_idx_t     dbg_addr,
  output logic [31:0] dbg_data
);

  logic [31:0] regs [`TOMA_NUM_REGS];
  tag_t        stat [`TOMA_NUM_REGS];

  // value or producer tag, with same-cycle bypass from the bus
  function automatic operand_t read_opnd(input reg_idx_t idx);
    operand_t o;
    o.value = regs[idx];
    o.tag   = stat[idx];
    if (o.tag != '0 && cdb.valid && cdb.tag == o.tag) begin
      o.value = cdb.value;
      o.tag   = '0;
    end
    return o;
  endfunction

  always_comb begin
    opnd_a = read_opnd(rd_addr_a);
    opnd_b = read_opnd(rd_addr_b);
  end

  assign dbg_data = regs[dbg_addr];

  always_ff @(posedge clk_100mhz or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `TOMA_NUM_REGS; i++) begin
        regs[i] <= '0;
        stat[i] <= '0;
      end
    end else begin
      for (int i = 1; i < `TOMA_NUM_REGS; i++) begin   // x0 stays 0, tag 0
        if (cdb.valid && stat[i] != '0 && stat[i] == cdb.tag) begin
          regs[i] <= cdb.value;
        end
        if (alloc_we && alloc_rd == reg_idx_t'(i)) begin
          stat[i] <= alloc_tag;   // newer producer wins
        end else if (cdb.valid && stat[i] != '0 && stat[i] == cdb.tag) begin
          stat[i] <= '0;
        end
      end
    end
  end

endmodule

//--- source/tomasulo_core.sv
`timescale 1ns/1ps
`include "tomasulo_defs.svh"

module tomasulo_core import tomasulo_pkg::*; (
  input wire          clk_100mhz,
  input wire          arst_n,
  input wire          instr_valid,
  input instr_word_u  instr,
  output logic        instr_ready,
  input reg_idx_t     reg_addr,
  output logic [31:0] reg_data,
  output cdb_t        cdb_out,
  output logic        idle
);

  issue_req_t rs1_issue;
  issue_req_t rs2_issue;
  logic       rs1_full;
  logic       rs2_full;
  tag_t       rs1_free_tag;
  tag_t       rs2_free_tag;
  reg_idx_t   rd_addr_a;
  reg_idx_t   rd_addr_b;
  operand_t   opnd_a;
  operand_t   opnd_b;
  logic       alloc_we;
  reg_idx_t   alloc_rd;
  tag_t       alloc_tag;
  cdb_t       rs1_result;
  cdb_t       rs2_result;
  logic       grant1;
  logic       grant2;
  logic       rs1_busy;
  logic       rs2_busy;
  cdb_t       cdb;

  issue_unit u_issue (
    .clk_100mhz (clk_100mhz),  .arst_n       (arst_n),
    .instr_valid(instr_valid), .instr        (instr),
    .instr_ready(instr_ready), .rs1_full     (rs1_full),
    .rs2_full   (rs2_full),    .rs1_free_tag (rs1_free_tag),
    .rs2_free_tag(rs2_free_tag), .rd_addr_a  (rd_addr_a),
    .rd_addr_b  (rd_addr_b),   .opnd_a       (opnd_a),
    .opnd_b     (opnd_b),      .alloc_we     (alloc_we),
    .alloc_rd   (alloc_rd),    .alloc_tag    (alloc_tag),
    .rs1_issue  (rs1_issue),   .rs2_issue    (rs2_issue)
  );

  // add, sub and logic ops
  reservation_station #(.ENTRIES(`TOMA_RS1_ENTRIES), .TAG_BASE(`TOMA_RS1_TAG_BASE)) u_rs_logic (
    .clk_100mhz(clk_100mhz), .arst_n(arst_n), .issue(rs1_issue), .full(rs1_full),
    .free_tag(rs1_free_tag), .cdb(cdb), .result(rs1_result), .grant(grant1),
    .busy_any(rs1_busy)
  );

  // shifts and compares
  reservation_station #(.ENTRIES(`TOMA_RS2_ENTRIES), .TAG_BASE(`TOMA_RS2_TAG_BASE)) u_rs_shift (
    .clk_100mhz(clk_100mhz), .arst_n(arst_n), .issue(rs2_issue), .full(rs2_full),
    .free_tag(rs2_free_tag), .cdb(cdb), .result(rs2_result), .grant(grant2),
    .busy_any(rs2_busy)
  );

  cdb_arbiter u_arbiter (
    .clk_100mhz(clk_100mhz), .arst_n(arst_n), .req1(rs1_result), .req2(rs2_result),
    .grant1(grant1), .grant2(grant2), .cdb(cdb)
  );

  reg_status_file u_regs (
    .clk_100mhz(clk_100mhz), .arst_n(arst_n), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .opnd_a(opnd_a), .opnd_b(opnd_b), .alloc_we(alloc_we), .alloc_rd(alloc_rd),
    .alloc_tag(alloc_tag), .cdb(cdb), .dbg_addr(reg_addr), .dbg_data(reg_data)
  );

  assign cdb_out = cdb;
  assign idle    = !(rs1_busy || rs2_busy || rs1_result.valid || rs2_result.valid);

endmodule

//--- sim/tomasulo_properties.sv
`timescale 1ns/1ps

module tomasulo_properties import tomasulo_pkg::*; (
  input wire  clk_100mhz,
  input wire  arst_n,
  input wire  grant1,
  input wire  grant2,
  input wire  instr_ready,
  input wire  rs1_busy,
  input wire  rs2_busy,
  input cdb_t rs1_result,
  input cdb_t rs2_result,
  input cdb_t cdb
);

  one_grant: assert property (@(posedge clk_100mhz) disable iff (!arst_n)
    !(grant1 && grant2)) else $error("both stations granted in one cycle");

  // a waiting result must not change
  rs1_hold: assert property (@(posedge clk_100mhz) disable iff (!arst_n)
    rs1_result.valid && !grant1 |=> $stable(rs1_result)) else $error("station one result moved");

  rs2_hold: assert property (@(posedge clk_100mhz) disable iff (!arst_n)
    rs2_result.valid && !grant2 |=> $stable(rs2_result)) else $error("station two result moved");

  cdb_tag: assert property (@(posedge clk_100mhz) disable iff (!arst_n)
    cdb.valid |-> cdb.tag != '0) else $error("CDB valid with tag 0");

  ready_empty: assert property (@(posedge clk_100mhz) disable iff (!arst_n)
    !rs1_busy && !rs2_busy |-> instr_ready) else $error("issue stalled with empty stations");

endmodule

bind tomasulo_core tomasulo_properties i_tomasulo_properties (
  .clk_100mhz  (clk_100mhz),
  .arst_n      (arst_n),
  .grant1      (grant1),
  .grant2      (grant2),
  .instr_ready (instr_ready),
  .rs1_busy    (rs1_busy),
  .rs2_busy    (rs2_busy),
  .rs1_result  (rs1_result),
  .rs2_result  (rs2_result),
  .cdb         (cdb)
);

//--- sim/tomasulo_tb.sv
`timescale 1ns/1ps
`include "tomasulo_defs.svh"

module tomasulo_tb import tomasulo_pkg::*; ();

  localparam int NUM_INSTRS      = 264;
  localparam int WATCHDOG_CYCLES = 16 + NUM_INSTRS * 40 + 1000;
  localparam int DRAIN_LIMIT     = 300;
  localparam logic [6:0] OPC_OP  = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;

  logic        clk_100mhz;
  logic        arst_n;
  logic        instr_valid;
  instr_word_u instr;
  logic        instr_ready;
  reg_idx_t    reg_addr;
  logic [31:0] reg_data;
  cdb_t        cdb_out;
  logic        idle;

  logic [31:0] model [`TOMA_NUM_REGS];   // architectural state in program order
  logic [31:0] rng;
  int          cdb_pulses;
  int          stall_cycles;

  tomasulo_core i_tomasulo_core (
    .clk_100mhz  (clk_100mhz),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .reg_addr    (reg_addr),
    .reg_data    (reg_data),
    .cdb_out     (cdb_out),
    .idle        (idle)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_IMM};
  endfunction

  // RV32I semantics of one OP or OP-IMM word on the model registers
  function automatic logic [31:0] ref_exec(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    a  = model[w[19:15]];
    b  = (w[6:0] == OPC_OP) ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
    sh = b[4:0];
    case (w[14:12])
      3'b000:  return (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
      3'b001:  return a << sh;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return w[30] ? 32'($signed(a) >>> sh) : a >> sh;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // called on a rising edge, returns on the edge that takes the word
  task automatic issue_instr(input logic [31:0] w);
    logic ready;
    instr_valid <= 1'b1;
    instr       <= w;
    do begin
      @(negedge clk_100mhz);
      ready = instr_ready;
      if (!ready) begin
        stall_cycles++;
      end
      @(posedge clk_100mhz);
    end while (!ready);
    if (w[11:7] != 5'd0) begin
      model[w[11:7]] = ref_exec(w);
    end
  endtask

  task automatic drain_and_compare();
    int waited;
    instr_valid <= 1'b0;
    waited = 0;
    @(negedge clk_100mhz);
    while (!idle && waited < DRAIN_LIMIT) begin
      waited++;
      @(negedge clk_100mhz);
    end
    if (!idle) begin
      abort_run("core did not go idle while draining");
    end
    for (int i = 1; i < `TOMA_NUM_REGS; i++) begin
      @(posedge clk_100mhz);
      reg_addr <= reg_idx_t'(i);
      @(negedge clk_100mhz);
      check_value($sformatf("reg_data[x%0d]", i), reg_data, model[i]);
    end
    @(posedge clk_100mhz);
  endtask

  task automatic test_all_ops();
    logic [11:0] imm;
    issue_instr(enc_i(3'b000, 5'd1, 5'd0, 12'hffb));   // -5
    issue_instr(enc_i(3'b000, 5'd2, 5'd0, 12'h003));
    issue_instr(enc_i(3'b000, 5'd3, 5'd0, 12'h555));
    issue_instr(enc_i(3'b000, 5'd4, 5'd0, 12'hc00));   // -1024
    for (int p = 0; p < 2; p++) begin
      for (int f = 0; f < 8; f++) begin
        issue_instr(enc_r(7'h00, 3'(f), 5'(5 + f + 8 * p), p ? 5'd4 : 5'd1, p ? 5'd3 : 5'd2));
      end
    end
    issue_instr(enc_r(7'h20, 3'b000, 5'd21, 5'd2, 5'd1));
    issue_instr(enc_r(7'h20, 3'b000, 5'd22, 5'd3, 5'd4));
    issue_instr(enc_r(7'h20, 3'b101, 5'd23, 5'd4, 5'd2));   // sra of a negative value
    for (int f = 0; f < 8; f++) begin
      imm = (f == 1) ? 12'h007 : (f == 5) ? 12'h407 : 12'hffc;
      issue_instr(enc_i(3'(f), 5'(24 + f), 5'd4, imm));
    end
    drain_and_compare();
  endtask

  task automatic test_raw_chain();
    issue_instr(enc_i(3'b000, 5'd6, 5'd0, 12'h005));
    issue_instr(enc_i(3'b000, 5'd7, 5'd0, 12'h003));
    issue_instr(enc_i(3'b000, 5'd8, 5'd0, 12'h001));
    for (int i = 0; i < 10; i++) begin
      if (i % 2 == 0) begin
        issue_instr(enc_r(7'h00, 3'b000, 5'd6, 5'd6, 5'd7));
      end else begin
        issue_instr(enc_r(7'h00, 3'b001, 5'd6, 5'd6, 5'd8));
      end
    end
    drain_and_compare();
  endtask

  task automatic test_back_pressure();
    int pulses_before;
    int stalls_before;
    pulses_before = cdb_pulses;
    for (int i = 0; i < 4; i++) begin
      issue_instr(enc_i(3'b001, 5'd9, 5'd9, 12'h001));   // shift chain
    end
    stalls_before = stall_cycles;
    for (int i = 0; i < 8; i++) begin
      issue_instr(enc_r(7'h00, 3'b000, 5'(10 + i % 6), 5'd1, 5'd2));   // station one burst
    end
    drain_and_compare();
    check_value("cdb_out.valid pulses", 32'(cdb_pulses - pulses_before), 32'd12);
    check_value("instr_ready stall", (stall_cycles > stalls_before) ? 32'd1 : 32'd0, 32'd1);
  endtask

  task automatic test_waw();
    issue_instr(enc_i(3'b101, 5'd21, 5'd4, 12'h401));
    issue_instr(enc_i(3'b101, 5'd21, 5'd21, 12'h401));
    issue_instr(enc_r(7'h00, 3'b001, 5'd20, 5'd21, 5'd2));   // slow writer
    issue_instr(enc_i(3'b000, 5'd20, 5'd0, 12'h04d));        // fast writer
    issue_instr(enc_r(7'h00, 3'b100, 5'd20, 5'd3, 5'd1));    // last in order
    drain_and_compare();
  endtask

  task automatic test_x0_writes();
    issue_instr(enc_i(3'b000, 5'd0, 5'd0, 12'h07b));
    issue_instr(enc_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
    issue_instr(enc_i(3'b001, 5'd0, 5'd1, 12'h004));
    drain_and_compare();
    reg_addr <= '0;
    @(negedge clk_100mhz);
    check_value("reg_data[x0]", reg_data, 32'd0);
    @(posedge clk_100mhz);
  endtask

  task automatic test_random_program();
    logic [31:0] r;
    logic [11:0] imm;
    logic [6:0]  f7;
    for (int n = 0; n < 200; n++) begin
      rng = lcg_next(rng);
      r   = rng;
      f7  = (r[27] && (r[30:28] == 3'b000 || r[30:28] == 3'b101)) ? 7'h20 : 7'h00;
      if (r[31]) begin
        issue_instr(enc_r(f7, r[30:28], {2'b00, r[26:24]}, {2'b00, r[23:21]},
                          {2'b00, r[20:18]}));
      end else begin
        imm = r[17:6];
        if (r[30:28] == 3'b001 || r[30:28] == 3'b101) begin
          imm = {f7, r[10:6]};   // shamt form
        end
        issue_instr(enc_i(r[30:28], {2'b00, r[26:24]}, {2'b00, r[23:21]}, imm));
      end
    end
    drain_and_compare();
  endtask

  always @(negedge clk_100mhz) begin
    if (arst_n && cdb_out.valid) begin
      cdb_pulses++;
      if (cdb_out.tag == '0) begin
        abort_run("CDB pulse carried the reserved tag 0");
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_100mhz);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    clk_100mhz   = 1'b0;
    arst_n       = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    reg_addr     = '0;
    cdb_pulses   = 0;
    stall_cycles = 0;
    rng          = 32'ha5eb;
    for (int i = 0; i < `TOMA_NUM_REGS; i++) begin
      model[i] = '0;
    end
    repeat (16) @(posedge clk_100mhz);
    arst_n <= 1'b1;
    @(negedge clk_100mhz);
    check_value("instr_ready", {31'd0, instr_ready}, 32'd1);
    check_value("idle", {31'd0, idle}, 32'd1);
    @(posedge clk_100mhz);
    test_all_ops();
    test_raw_chain();
    test_back_pressure();
    test_waw();
    test_x0_writes();
    test_random_program();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/tomasulo_pkg.sv
source/alu.sv
source/issue_unit.sv
source/reservation_station.sv
source/cdb_arbiter.sv
source/reg_status_file.sv
source/tomasulo_core.sv
sim/tomasulo_properties.sv
sim/tomasulo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; a failing run exits nonzero.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tomasulo_tb -f flist.f
./obj_dir/Vtomasulo_tb
